// ==== tb.f ====
mmu_cfg_pkg.sv
mmu_bus_pkg.sv
true_dpram_sclk.sv
immu.sv
fetch_unit.sv
wb_arbiter.sv
wb_ram.sv
immu_top.sv
tb_immu_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_immu_top \
   -f tb.f -o sim_tb > build.log 2>&1 \
   && ./obj_dir/sim_tb > sim.log 2>&1
grep -q "TEST PASSED" sim.log 2>/dev/null \
   && echo "Simulation succeeded, see sim.log" \
   || { echo "Simulation did not pass, see build.log and sim.log"; exit 1; }

// ==== tb_immu_top.sv ====
// Self-checking testbench for the instruction MMU top level that runs SPR, fetch, walk and bus tests
`timescale 1ns/1ns

module tb_immu_top;

   localparam int TIMEOUT = 500;

   logic                    clk;
   logic                    rst;
   mmu_bus_pkg::fetch_req_s fetch_req;
   logic                    fetch_ready;
   mmu_bus_pkg::fetch_rsp_s fetch_rsp;
   mmu_bus_pkg::wb_req_s    spr_req, ext_req;
   mmu_bus_pkg::wb_rsp_s    spr_rsp, ext_rsp;
   mmu_cfg_pkg::data_t      model [16384];
   mmu_cfg_pkg::addr_t      ext_addrs [$];
   integer                  seed = 32'h101;

   immu_top i_immu_top (
      .clk           (clk),
      .rst           (rst),
      .fetch_req_i   (fetch_req),
      .fetch_ready_o (fetch_ready),
      .fetch_rsp_o   (fetch_rsp),
      .spr_wb_i      (spr_req),
      .spr_wb_o      (spr_rsp),
      .ext_wb_i      (ext_req),
      .ext_wb_o      (ext_rsp)
   );

   always #4 clk = ~clk;

   task automatic stop_on_mismatch(input string msg);
      $display("MISMATCH at %0t ns: %s", $time, msg);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic stop_on_timeout(input string what);
      $display("Timed out at %0t ns while waiting for %s", $time, what);
      $display("TEST FAILED");
      $fatal(1);
   endtask

   // Acks last one cycle and done pulses once
   assert property (@(posedge clk) disable iff (rst) spr_rsp.ack |=> !spr_rsp.ack)
      else stop_on_mismatch("SPR ack held longer than one cycle");
   assert property (@(posedge clk) disable iff (rst) fetch_rsp.done |=> !fetch_rsp.done)
      else stop_on_mismatch("fetch done held longer than one cycle");

   // Ack only to one master that holds cyc
   always @(negedge clk) begin
      int acks;
      acks = 0;
      if (!rst) begin
         for (int i = 0; i < 3; i++) begin
            if (i_immu_top.i_wb_arbiter.m_rsp_o[i].ack) begin
               acks++;
               assert (i_immu_top.i_wb_arbiter.m_req_i[i].cyc)
                  else stop_on_mismatch($sformatf("ack to idle master %0d", i));
            end
         end
         assert (acks <= 1) else stop_on_mismatch("ack to more than one master");
      end
   end

   // Address rules of the two-level walk
   function automatic mmu_cfg_pkg::addr_t ptr_addr(input mmu_cfg_pkg::data_t cr,
                                                   input mmu_cfg_pkg::addr_t va);
      return {cr[31:10], va[31:24], 2'b00};
   endfunction

   function automatic mmu_cfg_pkg::addr_t pte_addr(input mmu_cfg_pkg::data_t ptr,
                                                   input mmu_cfg_pkg::addr_t va);
      return {ptr[31:13], va[23:13], 2'b00};
   endfunction

   function automatic mmu_cfg_pkg::addr_t phys(input mmu_cfg_pkg::data_t entry,
                                               input mmu_cfg_pkg::addr_t va);
      return {entry[31:13], va[12:0]};
   endfunction

   // Generic classic cycle on the external port
   task automatic ext_access(input logic we, input mmu_cfg_pkg::addr_t adr,
                             input mmu_cfg_pkg::data_t wdat, output mmu_cfg_pkg::data_t rdat);
      int n;
      n = 0;
      @(posedge clk);
      ext_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
      @(negedge clk);
      while (!ext_rsp.ack) begin
         n++;
         if (n > TIMEOUT)
            stop_on_timeout("external bus ack");
         @(negedge clk);
      end
      rdat = ext_rsp.dat;
      @(posedge clk);
      ext_req <= '0;
   endtask

   task automatic mem_write(input mmu_cfg_pkg::addr_t adr, input mmu_cfg_pkg::data_t d);
      mmu_cfg_pkg::data_t unused;
      ext_access(1'b1, adr, d, unused);
      // Only bits 15..2 select the word
      model[adr[15:2]] = d;
   endtask

   task automatic mem_read_check(input mmu_cfg_pkg::addr_t adr);
      mmu_cfg_pkg::data_t got;
      ext_access(1'b0, adr, '0, got);
      assert (got == model[adr[15:2]])
         else stop_on_mismatch($sformatf("mem %h read %h, expected %h",
                                         adr, got, model[adr[15:2]]));
   endtask

   task automatic spr_access(input logic we, input mmu_cfg_pkg::spr_addr_t adr,
                             input mmu_cfg_pkg::data_t wdat, output mmu_cfg_pkg::data_t rdat);
      int n;
      n = 0;
      @(posedge clk);
      spr_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: {16'h0, adr}, dat: wdat};
      @(negedge clk);
      while (!spr_rsp.ack) begin
         n++;
         if (n > TIMEOUT)
            stop_on_timeout("SPR ack");
         @(negedge clk);
      end
      rdat = spr_rsp.dat;
      @(posedge clk);
      spr_req <= '0;
   endtask

   task automatic spr_write(input mmu_cfg_pkg::spr_addr_t adr, input mmu_cfg_pkg::data_t d);
      mmu_cfg_pkg::data_t unused;
      spr_access(1'b1, adr, d, unused);
   endtask

   task automatic spr_check(input mmu_cfg_pkg::spr_addr_t adr, input mmu_cfg_pkg::data_t exp);
      mmu_cfg_pkg::data_t got;
      spr_access(1'b0, adr, '0, got);
      assert (got == exp)
         else stop_on_mismatch($sformatf("SPR %h read %h, expected %h", adr, got, exp));
   endtask

   // One fetch and then a compare of flags and word
   task automatic fetch_check(input mmu_cfg_pkg::addr_t va, input logic sup,
                              input logic exp_pf, input logic exp_miss,
                              input mmu_cfg_pkg::addr_t exp_pa);
      int n;
      n = 0;
      @(negedge clk);
      while (!fetch_ready) begin
         n++;
         if (n > TIMEOUT)
            stop_on_timeout("fetch ready");
         @(negedge clk);
      end
      @(posedge clk);
      fetch_req <= '{valid: 1'b1, vaddr: va, supervisor: sup};
      @(posedge clk);
      fetch_req <= '0;
      n = 0;
      @(negedge clk);
      while (!fetch_rsp.done) begin
         n++;
         if (n > TIMEOUT)
            stop_on_timeout("fetch done");
         @(negedge clk);
      end
      assert (fetch_rsp.pagefault == exp_pf && fetch_rsp.tlbmiss == exp_miss)
         else stop_on_mismatch($sformatf("fetch %h flags pf=%b miss=%b", va,
                                         fetch_rsp.pagefault, fetch_rsp.tlbmiss));
      if (!exp_pf && !exp_miss) begin
         assert (fetch_rsp.insn == model[exp_pa[15:2]])
            else stop_on_mismatch($sformatf("fetch %h got %h, expected %h", va,
                                            fetch_rsp.insn, model[exp_pa[15:2]]));
      end
   endtask

   // Random traffic in the top 4 KB away from tables and pages
   task automatic ext_traffic(input int ops);
      mmu_cfg_pkg::addr_t a;
      for (int i = 0; i < ops; i++) begin
         if (ext_addrs.size() == 0 || $random(seed) % 2 == 0) begin
            a = 32'h0000_F000 | ($random(seed) & 32'h0000_0FFC);
            mem_write(a, $random(seed));
            ext_addrs.push_back(a);
         end else begin
            mem_read_check(ext_addrs[{$random(seed)} % ext_addrs.size()]);
         end
      end
   endtask

   initial begin
      mmu_cfg_pkg::data_t cr, pte, d;
      mmu_cfg_pkg::data_t words [6];
      mmu_cfg_pkg::addr_t va;
      clk       = 1'b0;
      rst       = 1'b1;
      fetch_req = '0;
      spr_req   = '0;
      ext_req   = '0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      // SPR write and read back
      d = $random(seed);
      spr_write(mmu_cfg_pkg::IMMUCR_ADDR, d);
      spr_check(mmu_cfg_pkg::IMMUCR_ADDR, d);
      for (int i = 0; i < 6; i++) begin
         words[i] = $random(seed);
         spr_write(mmu_cfg_pkg::ITLB_MATCH_BASE + 16'(i * 9), words[i]);
         spr_write(mmu_cfg_pkg::ITLB_TRANS_BASE + 16'(i * 9), ~words[i]);
      end
      for (int i = 0; i < 6; i++) begin
         spr_check(mmu_cfg_pkg::ITLB_MATCH_BASE + 16'(i * 9), words[i]);
         spr_check(mmu_cfg_pkg::ITLB_TRANS_BASE + 16'(i * 9), ~words[i]);
      end

      // Software-loaded hit with set 1 mapped onto page 3
      spr_write(mmu_cfg_pkg::IMMUCR_ADDR, '0);
      for (int i = 0; i < 64; i++)
         spr_write(mmu_cfg_pkg::ITLB_MATCH_BASE + 16'(i), '0);
      va = 32'h0040_2A10;
      spr_write(mmu_cfg_pkg::ITLB_MATCH_BASE + 16'(va[18:13]), {va[31:13], 13'h1});
      spr_write(mmu_cfg_pkg::ITLB_TRANS_BASE + 16'(va[18:13]), {19'h3, 13'h0c0});
      mem_write(phys({19'h3, 13'h0}, va), $random(seed));
      mem_write(phys({19'h3, 13'h0}, va) + 4, $random(seed));
      fetch_check(va, 1'b0, 1'b0, 1'b0, phys({19'h3, 13'h0}, va));

      // Hardware reload through table base 0x4000 and second level page 4
      cr = 32'h0000_4000;
      spr_write(mmu_cfg_pkg::IMMUCR_ADDR, cr);
      va = 32'h0A00_6120;
      mem_write(ptr_addr(cr, va), 32'h0000_8000);
      pte = {19'h5, 13'h043};
      mem_write(pte_addr(32'h0000_8000, va), pte);
      mem_write(phys(pte, va), $random(seed));
      fetch_check(va, 1'b0, 1'b0, 1'b0, phys(pte, va));
      spr_check(mmu_cfg_pkg::ITLB_MATCH_BASE + 16'(va[18:13]), {va[31:13], 13'h1});
      spr_check(mmu_cfg_pkg::ITLB_TRANS_BASE + 16'(va[18:13]), {pte[31:13], 13'h0c2});

      // Zero pointer and then a PTE that is not present
      mem_write(ptr_addr(cr, 32'h0B00_2040), '0);
      // Executable PTE behind the zero pointer that the walker must never reach
      mem_write(pte_addr('0, 32'h0B00_2040), {19'h7, 13'h0c1});
      fetch_check(32'h0B00_2040, 1'b0, 1'b1, 1'b0, '0);
      mem_write(pte_addr(32'h0000_8000, 32'h0A00_8040), 32'h0000_C040);
      fetch_check(32'h0A00_8040, 1'b1, 1'b1, 1'b0, '0);
      // Fault must be gone for the next walk
      va = 32'h0A00_A300;
      pte = {19'h6, 13'h041};
      mem_write(pte_addr(32'h0000_8000, va), pte);
      mem_write(phys(pte, va), $random(seed));
      fetch_check(va, 1'b0, 1'b0, 1'b0, phys(pte, va));

      // Supervisor-only page and then a miss with the walk off
      va = 32'h0100_4800;
      spr_write(mmu_cfg_pkg::ITLB_MATCH_BASE + 16'(va[18:13]), {va[31:13], 13'h1});
      spr_write(mmu_cfg_pkg::ITLB_TRANS_BASE + 16'(va[18:13]), {19'h2, 13'h040});
      mem_write(phys({19'h2, 13'h0}, va), $random(seed));
      fetch_check(va, 1'b0, 1'b1, 1'b0, '0);
      fetch_check(va, 1'b1, 1'b0, 1'b0, phys({19'h2, 13'h0}, va));
      spr_write(mmu_cfg_pkg::IMMUCR_ADDR, '0);
      fetch_check(32'h0300_E000, 1'b1, 1'b0, 1'b1, '0);

      // Reload under external traffic
      spr_write(mmu_cfg_pkg::IMMUCR_ADDR, cr);
      va = 32'h0A00_C400;
      pte = {19'h1, 13'h081};
      mem_write(pte_addr(32'h0000_8000, va), pte);
      mem_write(phys(pte, va), $random(seed));
      fork
         fetch_check(va, 1'b0, 1'b0, 1'b0, phys(pte, va));
         ext_traffic(24);
      join
      ext_traffic(8);

      $display("TEST PASSED");
      $finish;
   end

endmodule

// ==== immu_top.sv ====
// Top level joining the instruction MMU, fetch unit, bus arbiter and shared memory
`timescale 1ns/1ns

module immu_top (
   input  logic                     clk,
   input  logic                     rst,
   input  mmu_bus_pkg::fetch_req_s  fetch_req_i,
   output logic                     fetch_ready_o,
   output mmu_bus_pkg::fetch_rsp_s  fetch_rsp_o,
   input  mmu_bus_pkg::wb_req_s     spr_wb_i,
   output mmu_bus_pkg::wb_rsp_s     spr_wb_o,
   input  mmu_bus_pkg::wb_req_s     ext_wb_i,
   output mmu_bus_pkg::wb_rsp_s     ext_wb_o
);

   mmu_cfg_pkg::addr_t    lookup_vaddr, match_vaddr, phys_addr;
   logic                  supervisor;
   logic                  tlb_miss, pagefault;
   logic                  reload_busy, reload_fault, reload_fault_clear;
   mmu_bus_pkg::wb_req_s  walk_req, fetch_req, ram_req;
   mmu_bus_pkg::wb_rsp_s  ram_rsp;
   // Arbiter ports: 0 external, 1 walker, 2 fetch
   mmu_bus_pkg::wb_rsp_s [mmu_bus_pkg::NUM_MASTERS-1:0] arb_rsp;

   assign ext_wb_o = arb_rsp[0];

   immu i_immu (
      .clk                  (clk),
      .rst                  (rst),
      .lookup_vaddr_i       (lookup_vaddr),
      .match_vaddr_i        (match_vaddr),
      .supervisor_i         (supervisor),
      .phys_addr_o          (phys_addr),
      .cache_inhibit_o      (),
      .tlb_miss_o           (tlb_miss),
      .pagefault_o          (pagefault),
      .reload_busy_o        (reload_busy),
      .reload_fault_o       (reload_fault),
      .reload_fault_clear_i (reload_fault_clear),
      .walk_wb_o            (walk_req),
      .walk_wb_i            (arb_rsp[1]),
      .spr_wb_i             (spr_wb_i),
      .spr_wb_o             (spr_wb_o)
   );

   fetch_unit i_fetch_unit (
      .clk                  (clk),
      .rst                  (rst),
      .fetch_req_i          (fetch_req_i),
      .fetch_ready_o        (fetch_ready_o),
      .fetch_rsp_o          (fetch_rsp_o),
      .lookup_vaddr_o       (lookup_vaddr),
      .match_vaddr_o        (match_vaddr),
      .supervisor_o         (supervisor),
      .phys_addr_i          (phys_addr),
      .tlb_miss_i           (tlb_miss),
      .pagefault_i          (pagefault),
      .reload_busy_i        (reload_busy),
      .reload_fault_i       (reload_fault),
      .reload_fault_clear_o (reload_fault_clear),
      .fetch_wb_o           (fetch_req),
      .fetch_wb_i           (arb_rsp[2])
   );

   wb_arbiter i_wb_arbiter (
      .clk     (clk),
      .rst     (rst),
      .m_req_i ({fetch_req, walk_req, ext_wb_i}),
      .m_rsp_o (arb_rsp),
      .s_req_o (ram_req),
      .s_rsp_i (ram_rsp)
   );

   wb_ram i_wb_ram (
      .clk  (clk),
      .rst  (rst),
      .wb_i (ram_req),
      .wb_o (ram_rsp)
   );

endmodule

// ==== wb_ram.sv ====
// Shared word memory behind a Wishbone classic slave port with a registered ack
`timescale 1ns/1ns

module wb_ram (
   input  logic                  clk,
   input  logic                  rst,
   input  mmu_bus_pkg::wb_req_s  wb_i,
   output mmu_bus_pkg::wb_rsp_s  wb_o
);

   mmu_cfg_pkg::data_t             mem [2**mmu_bus_pkg::RAM_AW];
   mmu_cfg_pkg::data_t             rdata;
   logic [mmu_bus_pkg::RAM_AW-1:0] word_idx;
   logic                           ack;
   logic                           access;

   // Bits 15..2 only, higher bits alias
   assign word_idx = wb_i.adr[mmu_bus_pkg::RAM_AW+1:2];
   // New access unless ack is already up
   assign access = wb_i.cyc & wb_i.stb & ~ack;

   // Ack one cycle after stb, dropped right after
   always_ff @(posedge clk) begin
      if (rst)
         ack <= 1'b0;
      else
         ack <= access;
   end

   always_ff @(posedge clk) begin
      if (access) begin
         if (wb_i.we)
            mem[word_idx] <= wb_i.dat;
         rdata <= mem[word_idx];
      end
   end

   assign wb_o = '{ack: ack, dat: rdata};

endmodule

// ==== wb_arbiter.sv ====
// Round-robin Wishbone classic arbiter, three masters onto the shared memory
`timescale 1ns/1ns

module wb_arbiter (
   input  logic                                                 clk,
   input  logic                                                 rst,
   input  mmu_bus_pkg::wb_req_s [mmu_bus_pkg::NUM_MASTERS-1:0]  m_req_i,
   output mmu_bus_pkg::wb_rsp_s [mmu_bus_pkg::NUM_MASTERS-1:0]  m_rsp_o,
   output mmu_bus_pkg::wb_req_s                                 s_req_o,
   input  mmu_bus_pkg::wb_rsp_s                                 s_rsp_i
);

   logic [1:0] grant_q, ptr_q, pick;
   logic       owned_q, any_req, release_bus;

   // First requester at or after the pointer
   always_comb begin
      int unsigned idx;
      pick    = ptr_q;
      any_req = 1'b0;
      for (int i = mmu_bus_pkg::NUM_MASTERS - 1; i >= 0; i--) begin
         idx = (int'(ptr_q) + i) % mmu_bus_pkg::NUM_MASTERS;
         if (m_req_i[idx].cyc) begin
            pick    = idx[1:0];
            any_req = 1'b1;
         end
      end
   end

   // Bus is free when nobody owns it or the owner dropped cyc
   assign release_bus = ~owned_q | ~m_req_i[grant_q].cyc;

   always_ff @(posedge clk) begin
      if (rst) begin
         grant_q <= '0;
         ptr_q   <= '0;
         owned_q <= 1'b0;
      end else if (release_bus) begin
         owned_q <= any_req;
         if (any_req) begin
            grant_q <= pick;
            ptr_q   <= (pick == 2'(mmu_bus_pkg::NUM_MASTERS - 1)) ? 2'd0 : pick + 2'd1;
         end
      end
   end

   assign s_req_o = owned_q ? m_req_i[grant_q] : '0;

   // Others see ack low as back-pressure
   always_comb begin
      for (int i = 0; i < mmu_bus_pkg::NUM_MASTERS; i++) begin
         m_rsp_o[i] = '0;
         if (owned_q && grant_q == 2'(i))
            m_rsp_o[i] = s_rsp_i;
      end
   end

endmodule

// ==== fetch_unit.sv ====
// Instruction fetch FSM, sequences ITLB lookup, reload wait and the memory read for one fetch
`timescale 1ns/1ns

module fetch_unit (
   input  logic                     clk,
   input  logic                     rst,
   input  mmu_bus_pkg::fetch_req_s  fetch_req_i,
   output logic                     fetch_ready_o,
   output mmu_bus_pkg::fetch_rsp_s  fetch_rsp_o,
   output mmu_cfg_pkg::addr_t       lookup_vaddr_o,
   output mmu_cfg_pkg::addr_t       match_vaddr_o,
   output logic                     supervisor_o,
   input  mmu_cfg_pkg::addr_t       phys_addr_i,
   input  logic                     tlb_miss_i,
   input  logic                     pagefault_i,
   input  logic                     reload_busy_i,
   input  logic                     reload_fault_i,
   output logic                     reload_fault_clear_o,
   output mmu_bus_pkg::wb_req_s     fetch_wb_o,
   input  mmu_bus_pkg::wb_rsp_s     fetch_wb_i
);

   mmu_bus_pkg::fetch_state_e state;
   mmu_cfg_pkg::addr_t        vaddr_q;
   logic                      super_q;

   assign fetch_ready_o = (state == mmu_bus_pkg::IDLE);
   // Set index goes out in the accept cycle, then held
   assign lookup_vaddr_o = fetch_ready_o ? fetch_req_i.vaddr : vaddr_q;
   assign match_vaddr_o  = vaddr_q;
   assign supervisor_o   = super_q;
   // Fault cleared on completion and kept clear while idle
   assign reload_fault_clear_o = fetch_ready_o | (state == mmu_bus_pkg::DONE);

   always_ff @(posedge clk) begin
      if (rst) begin
         state       <= mmu_bus_pkg::IDLE;
         fetch_wb_o  <= '0;
         fetch_rsp_o <= '0;
      end else begin
         case (state)
            mmu_bus_pkg::IDLE: begin
               if (fetch_req_i.valid)
                  state <= mmu_bus_pkg::LOOKUP;
            end
            mmu_bus_pkg::LOOKUP: begin
               fetch_rsp_o.insn      <= '0;
               fetch_rsp_o.pagefault <= 1'b0;
               fetch_rsp_o.tlbmiss   <= 1'b0;
               if (reload_busy_i) begin
                  state <= mmu_bus_pkg::RELOAD;
               end else if (reload_fault_i || (!tlb_miss_i && pagefault_i)) begin
                  fetch_rsp_o.done      <= 1'b1;
                  fetch_rsp_o.pagefault <= 1'b1;
                  state                 <= mmu_bus_pkg::DONE;
               end else if (tlb_miss_i) begin
                  // Walk disabled
                  fetch_rsp_o.done    <= 1'b1;
                  fetch_rsp_o.tlbmiss <= 1'b1;
                  state               <= mmu_bus_pkg::DONE;
               end else begin
                  fetch_wb_o.cyc <= 1'b1;
                  fetch_wb_o.stb <= 1'b1;
                  fetch_wb_o.adr <= phys_addr_i;
                  state          <= mmu_bus_pkg::READ;
               end
            end
            // Retry the lookup once the walker is done
            mmu_bus_pkg::RELOAD: begin
               if (!reload_busy_i)
                  state <= mmu_bus_pkg::LOOKUP;
            end
            mmu_bus_pkg::READ: begin
               if (fetch_wb_i.ack) begin
                  fetch_wb_o.cyc   <= 1'b0;
                  fetch_wb_o.stb   <= 1'b0;
                  fetch_rsp_o.insn <= fetch_wb_i.dat;
                  fetch_rsp_o.done <= 1'b1;
                  state            <= mmu_bus_pkg::DONE;
               end
            end
            // Done pulse lasts this one cycle
            mmu_bus_pkg::DONE: begin
               fetch_rsp_o.done <= 1'b0;
               state            <= mmu_bus_pkg::IDLE;
            end
            default: state <= mmu_bus_pkg::IDLE;
         endcase
      end
   end

   // Request payload, no reset
   always_ff @(posedge clk) begin
      if (fetch_ready_o && fetch_req_i.valid) begin
         vaddr_q <= fetch_req_i.vaddr;
         super_q <= fetch_req_i.supervisor;
      end
   end

endmodule

// ==== immu.sv ====
// Instruction MMU: ITLB lookup, SPR access, execute permission check and hardware table walker
`timescale 1ns/1ns

module immu (
   input  logic                  clk,
   input  logic                  rst,
   input  mmu_cfg_pkg::addr_t    lookup_vaddr_i,
   input  mmu_cfg_pkg::addr_t    match_vaddr_i,
   input  logic                  supervisor_i,
   output mmu_cfg_pkg::addr_t    phys_addr_o,
   output logic                  cache_inhibit_o,
   output logic                  tlb_miss_o,
   output logic                  pagefault_o,
   output logic                  reload_busy_o,
   output logic                  reload_fault_o,
   input  logic                  reload_fault_clear_i,
   output mmu_bus_pkg::wb_req_s  walk_wb_o,
   input  mmu_bus_pkg::wb_rsp_s  walk_wb_i,
   input  mmu_bus_pkg::wb_req_s  spr_wb_i,
   output mmu_bus_pkg::wb_rsp_s  spr_wb_o
);

   mmu_cfg_pkg::walk_state_e walk_state;
   mmu_cfg_pkg::spr_addr_t   spr_adr;
   mmu_cfg_pkg::set_idx_t    tlb_set_a;
   mmu_cfg_pkg::vpn_t        match_vpn;
   mmu_cfg_pkg::data_t       match_dout_a, trans_dout_a;
   mmu_cfg_pkg::data_t       match_dout_b, trans_dout_b;
   mmu_cfg_pkg::data_t       walk_match_d, walk_trans_d;
   mmu_cfg_pkg::data_t       walk_match_q, walk_trans_q;
   mmu_cfg_pkg::data_t       immucr;
   mmu_cfg_pkg::data_t       spr_rdata;
   logic                     walk_we;
   logic                     spr_sel, spr_ack;
   logic                     match_cs, trans_cs, immucr_cs;
   logic                     match_cs_r, trans_cs_r, immucr_cs_r;
   logic                     reload_fault;
   logic                     do_reload;

   // SPR decode, group 2 only
   assign spr_adr = spr_wb_i.adr[15:0];
   assign spr_sel = spr_wb_i.cyc & spr_wb_i.stb & (spr_adr[15:11] == mmu_cfg_pkg::SPR_GROUP_MMU);
   assign match_cs = spr_sel & ((spr_adr >> mmu_cfg_pkg::SET_WIDTH) ==
                                (mmu_cfg_pkg::ITLB_MATCH_BASE >> mmu_cfg_pkg::SET_WIDTH));
   assign trans_cs = spr_sel & ((spr_adr >> mmu_cfg_pkg::SET_WIDTH) ==
                                (mmu_cfg_pkg::ITLB_TRANS_BASE >> mmu_cfg_pkg::SET_WIDTH));
   assign immucr_cs = spr_sel & (spr_adr == mmu_cfg_pkg::IMMUCR_ADDR);

   // One-cycle ack, selects registered to steer read data
   always_ff @(posedge clk) begin
      if (rst) begin
         spr_ack     <= 1'b0;
         match_cs_r  <= 1'b0;
         trans_cs_r  <= 1'b0;
         immucr_cs_r <= 1'b0;
      end else begin
         spr_ack     <= spr_sel & ~spr_ack;
         match_cs_r  <= match_cs;
         trans_cs_r  <= trans_cs;
         immucr_cs_r <= immucr_cs;
      end
   end

   // Page table base, written on the ack edge
   always_ff @(posedge clk) begin
      if (rst)
         immucr <= '0;
      else if (immucr_cs & spr_wb_i.we & spr_ack)
         immucr <= spr_wb_i.dat;
   end

   assign spr_rdata = match_cs_r  ? match_dout_b :
                      trans_cs_r  ? trans_dout_b :
                      immucr_cs_r ? immucr : '0;
   assign spr_wb_o = '{ack: spr_ack, dat: spr_rdata};

   // Lookup result, one cycle after the set was presented
   assign match_vpn = match_vaddr_i[31:mmu_cfg_pkg::PAGE_BITS];
   assign tlb_miss_o = (match_dout_a[31:mmu_cfg_pkg::PAGE_BITS] != match_vpn) |
                       ~match_dout_a[mmu_cfg_pkg::MATCH_VALID_BIT];
   assign phys_addr_o = {trans_dout_a[31:mmu_cfg_pkg::PAGE_BITS],
                         match_vaddr_i[mmu_cfg_pkg::PAGE_BITS-1:0]};
   assign cache_inhibit_o = trans_dout_a[mmu_cfg_pkg::TRANS_CI_BIT];
   // Execute right for the current mode
   assign pagefault_o = supervisor_i ? ~trans_dout_a[mmu_cfg_pkg::TRANS_SXE_BIT] :
                                       ~trans_dout_a[mmu_cfg_pkg::TRANS_UXE_BIT];

   // Walker owns port A set while running
   assign tlb_set_a = (walk_state != mmu_cfg_pkg::IDLE) ?
                      match_vaddr_i[mmu_cfg_pkg::PAGE_BITS +: mmu_cfg_pkg::SET_WIDTH] :
                      lookup_vaddr_i[mmu_cfg_pkg::PAGE_BITS +: mmu_cfg_pkg::SET_WIDTH];

   // Clear input held high while no fetch is active, so it also holds the walker off
   assign do_reload = (walk_state == mmu_cfg_pkg::IDLE) & tlb_miss_o &
                      (immucr[31:10] != '0) & ~reload_fault & ~reload_fault_clear_i;
   assign reload_busy_o  = (walk_state != mmu_cfg_pkg::IDLE) | do_reload;
   assign reload_fault_o = reload_fault & ~reload_fault_clear_i;

   // Entries built from the PTE on the data bus
   always_comb begin
      walk_match_d = '0;
      walk_match_d[31:mmu_cfg_pkg::PAGE_BITS] = match_vpn;
      walk_match_d[mmu_cfg_pkg::MATCH_VALID_BIT] = 1'b1;
      walk_trans_d = '0;
      walk_trans_d[31:mmu_cfg_pkg::PAGE_BITS] = walk_wb_i.dat[31:mmu_cfg_pkg::PAGE_BITS];
      walk_trans_d[mmu_cfg_pkg::TRANS_CI_BIT] = walk_wb_i.dat[mmu_cfg_pkg::PTE_CI_BIT];
      // Any read or write right grants execute in both modes
      walk_trans_d[mmu_cfg_pkg::TRANS_SXE_BIT] =
         |walk_wb_i.dat[mmu_cfg_pkg::PTE_RIGHTS_HI:mmu_cfg_pkg::PTE_RIGHTS_LO];
      walk_trans_d[mmu_cfg_pkg::TRANS_UXE_BIT] =
         |walk_wb_i.dat[mmu_cfg_pkg::PTE_RIGHTS_HI:mmu_cfg_pkg::PTE_RIGHTS_LO];
   end

   // Two-level walk, pointer word then PTE
   always_ff @(posedge clk) begin
      if (rst) begin
         walk_state   <= mmu_cfg_pkg::IDLE;
         walk_wb_o    <= '0;
         walk_we      <= 1'b0;
         reload_fault <= 1'b0;
      end else begin
         walk_we <= 1'b0;
         if (reload_fault_clear_i)
            reload_fault <= 1'b0;
         case (walk_state)
            mmu_cfg_pkg::IDLE: begin
               if (do_reload) begin
                  walk_wb_o.cyc <= 1'b1;
                  walk_wb_o.stb <= 1'b1;
                  walk_wb_o.adr <= {immucr[31:10], match_vaddr_i[31:24], 2'b00};
                  walk_state    <= mmu_cfg_pkg::GET_PTR;
               end
            end
            mmu_cfg_pkg::GET_PTR: begin
               if (walk_wb_i.ack) begin
                  if (walk_wb_i.dat[31:mmu_cfg_pkg::PAGE_BITS] == '0) begin
                     // No second-level table
                     reload_fault  <= 1'b1;
                     walk_wb_o.cyc <= 1'b0;
                     walk_wb_o.stb <= 1'b0;
                     walk_state    <= mmu_cfg_pkg::IDLE;
                  end else begin
                     // Next access follows directly
                     walk_wb_o.adr <= {walk_wb_i.dat[31:mmu_cfg_pkg::PAGE_BITS],
                                       match_vaddr_i[23:13], 2'b00};
                     walk_state    <= mmu_cfg_pkg::GET_PTE;
                  end
               end
            end
            mmu_cfg_pkg::GET_PTE: begin
               if (walk_wb_i.ack) begin
                  walk_wb_o.cyc <= 1'b0;
                  walk_wb_o.stb <= 1'b0;
                  if (!walk_wb_i.dat[mmu_cfg_pkg::PTE_PRESENT_BIT]) begin
                     reload_fault <= 1'b1;
                     walk_state   <= mmu_cfg_pkg::IDLE;
                  end else begin
                     walk_we    <= 1'b1;
                     walk_state <= mmu_cfg_pkg::SETTLE;
                  end
               end
            end
            // Entry write, new values reach port A output next
            mmu_cfg_pkg::SETTLE: walk_state <= mmu_cfg_pkg::IDLE;
            default: walk_state <= mmu_cfg_pkg::IDLE;
         endcase
      end
   end

   // Entry data, no reset
   always_ff @(posedge clk) begin
      if (walk_state == mmu_cfg_pkg::GET_PTE && walk_wb_i.ack) begin
         walk_match_q <= walk_match_d;
         walk_trans_q <= walk_trans_d;
      end
   end

   // Match entries
   true_dpram_sclk i_itlb_match (
      .clk      (clk),
      .addr_a_i (tlb_set_a),
      .we_a_i   (walk_we),
      .din_a_i  (walk_match_q),
      .dout_a_o (match_dout_a),
      .addr_b_i (spr_adr[mmu_cfg_pkg::SET_WIDTH-1:0]),
      .we_b_i   (match_cs & spr_wb_i.we & spr_ack),
      .din_b_i  (spr_wb_i.dat),
      .dout_b_o (match_dout_b)
   );

   // Translate entries
   true_dpram_sclk i_itlb_trans (
      .clk      (clk),
      .addr_a_i (tlb_set_a),
      .we_a_i   (walk_we),
      .din_a_i  (walk_trans_q),
      .dout_a_o (trans_dout_a),
      .addr_b_i (spr_adr[mmu_cfg_pkg::SET_WIDTH-1:0]),
      .we_b_i   (trans_cs & spr_wb_i.we & spr_ack),
      .din_b_i  (spr_wb_i.dat),
      .dout_b_o (trans_dout_b)
   );

endmodule

// ==== true_dpram_sclk.sv ====
// Single-clock true dual-port RAM with registered reads, holds one ITLB entry array
`timescale 1ns/1ns

module true_dpram_sclk (
   input  logic                   clk,
   input  mmu_cfg_pkg::set_idx_t  addr_a_i,
   input  logic                   we_a_i,
   input  mmu_cfg_pkg::data_t     din_a_i,
   output mmu_cfg_pkg::data_t     dout_a_o,
   input  mmu_cfg_pkg::set_idx_t  addr_b_i,
   input  logic                   we_b_i,
   input  mmu_cfg_pkg::data_t     din_b_i,
   output mmu_cfg_pkg::data_t     dout_b_o
);

   mmu_cfg_pkg::data_t mem [2**mmu_cfg_pkg::SET_WIDTH];

   // Both ports in one block, never the same address written twice
   always_ff @(posedge clk) begin
      if (we_a_i)
         mem[addr_a_i] <= din_a_i;
      if (we_b_i)
         mem[addr_b_i] <= din_b_i;
      // Write-first, new data shows on own port next cycle
      dout_a_o <= we_a_i ? din_a_i : mem[addr_a_i];
      dout_b_o <= we_b_i ? din_b_i : mem[addr_b_i];
   end

endmodule

// ==== mmu_bus_pkg.sv ====
// Bus package with Wishbone classic and fetch request/response structs, shared by all blocks
package mmu_bus_pkg;

   // External master, table walker, fetch unit
   localparam int NUM_MASTERS = 3;
   // Shared RAM word address width, 16384 words
   localparam int RAM_AW = 14;

   // Master-driven Wishbone signals
   typedef struct packed {
      logic                cyc;
      logic                stb;
      logic                we;
      mmu_cfg_pkg::addr_t  adr;
      mmu_cfg_pkg::data_t  dat;
   } wb_req_s;

   // Slave-driven Wishbone signals
   typedef struct packed {
      logic                ack;
      mmu_cfg_pkg::data_t  dat;
   } wb_rsp_s;

   typedef struct packed {
      logic                valid;
      mmu_cfg_pkg::addr_t  vaddr;
      logic                supervisor;
   } fetch_req_s;

   typedef struct packed {
      logic                done;
      mmu_cfg_pkg::data_t  insn;
      logic                pagefault;
      logic                tlbmiss;
   } fetch_rsp_s;

   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      RELOAD,
      READ,
      DONE
   } fetch_state_e;

endpackage

// ==== mmu_cfg_pkg.sv ====
// MMU configuration package with page geometry, SPR map, entry bit layout and walker states
package mmu_cfg_pkg;

   // 8 KB pages, 64 direct-mapped sets
   localparam int PAGE_BITS = 13;
   localparam int SET_WIDTH = 6;

   // Virtual or physical byte address
   typedef logic [31:0] addr_t;
   // Bus word, also used for PTEs and TLB entries
   typedef logic [31:0] data_t;
   // Page number, address bits 31..13
   typedef logic [31-PAGE_BITS:0] vpn_t;
   // TLB set index, virtual address bits 18..13
   typedef logic [SET_WIDTH-1:0] set_idx_t;
   typedef logic [15:0] spr_addr_t;

   // SPR group of the MMU, held in address bits 15..11
   localparam logic [4:0] SPR_GROUP_MMU = 5'd2;
   // Page table base register
   localparam spr_addr_t IMMUCR_ADDR = 16'h1000;
   // 64 match entries, then 64 translate entries
   localparam spr_addr_t ITLB_MATCH_BASE = 16'h1200;
   localparam spr_addr_t ITLB_TRANS_BASE = 16'h1280;

   // Match entry: VPN in 31..13, valid in bit 0
   localparam int MATCH_VALID_BIT = 0;

   // Translate entry: PPN in 31..13, plus flags
   localparam int TRANS_CI_BIT  = 1;
   localparam int TRANS_SXE_BIT = 6;
   localparam int TRANS_UXE_BIT = 7;

   // PTE: PPN in 31..13, present, cache inhibit and access rights
   localparam int PTE_PRESENT_BIT = 0;
   localparam int PTE_CI_BIT      = 1;
   localparam int PTE_RIGHTS_HI   = 10;
   localparam int PTE_RIGHTS_LO   = 6;

   // Hardware table walker
   typedef enum logic [1:0] {
      IDLE,
      GET_PTR,
      GET_PTE,
      SETTLE
   } walk_state_e;

endpackage
